/* Bender.yml */
package:
  name: cache_miss

sources:
  - files:
      - cache_pkg.sv
      - cache_mem_if.sv
      - cache_tag_mem.sv
      - cache_stat_mem.sv
      - cache_miss.sv
      - cache_miss_top.sv
  - target: test
    files:
      - cache_miss_assert.sv
      - tb_cache_miss_top.sv

/* cache_mem_if.sv */
// single access port of a cache memory, driven by the miss FSM and served by the memory
`timescale 1ns/10ps

interface cache_mem_if #(
  parameter int WIDTH = 8
);
  import cache_pkg::*;

  logic             v;       // access this cycle
  logic             w;       // write when set, read otherwise
  index_t           addr;
  logic [WIDTH-1:0] data;
  logic [WIDTH-1:0] w_mask;  // only bits set here are written

  modport requester (
    output v,
    output w,
    output addr,
    output data,
    output w_mask
  );

  modport memory (
    input v,
    input w,
    input addr,
    input data,
    input w_mask
  );

endinterface

/* cache_miss.sv */
// miss and maintenance FSM that combines tag and status reads and drives DMA and both memories
`timescale 1ns/10ps

module cache_miss #(
  parameter int ADDR_W      = 32,
  parameter int DATA_W      = 32,
  parameter int BLOCK_WORDS = 8,
  parameter int SETS        = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  miss_v_i,
  input  cache_pkg::cache_op_e  op_i,
  input  cache_pkg::addr_t      addr_i,

  input  cache_pkg::tag_t [1:0] tags_i,
  input  logic [1:0]            valid_i,
  input  logic [1:0]            hit_i,
  input  logic [1:0]            dirty_i,
  input  logic                  mru_i,

  input  logic                  sbuf_empty_i,
  input  logic                  dma_done_i,
  input  logic                  ack_i,

  output logic                  dma_send_fill_addr_o,
  output logic                  dma_send_evict_addr_o,
  output logic                  dma_get_fill_data_o,
  output logic                  dma_send_evict_data_o,
  output logic                  dma_set_o,
  output cache_pkg::addr_t      dma_addr_o,
  output logic                  recover_o,
  output logic                  done_o,
  output cache_pkg::way_t       chosen_set_o,

  cache_mem_if.requester        tag_if,
  cache_mem_if.requester        stat_if
);
  import cache_pkg::*;

  localparam int MASK_W   = clog2_safe(DATA_W / 8);
  localparam int BLK_W    = clog2_safe(BLOCK_WORDS);
  localparam int IDX_W    = clog2_safe(SETS);
  localparam int TAG_BITS = tag_width(ADDR_W, DATA_W, BLOCK_WORDS, SETS);

  miss_state_e state_r, state_n;
  way_t        chosen_set_r, chosen_set_n;
  logic        stat_flopped_r, stat_flopped_n;
  logic [1:0]  dirty_r, dirty_n;
  logic        mru_r, mru_n;

  tag_t             addr_tag;
  index_t           addr_index;
  way_t             addr_way;
  logic [BLK_W-1:0] addr_word;

  logic is_flush;
  logic is_store;
  logic is_inv;  // maintenance kinds that drop the line

  tag_entry_t [1:0] tag_wdata;
  tag_entry_t [1:0] tag_wmask;

  assign addr_word  = addr_i[MASK_W +: BLK_W];
  assign addr_index = addr_i[MASK_W+BLK_W +: IDX_W];
  assign addr_tag   = addr_i[MASK_W+BLK_W+IDX_W +: TAG_BITS];
  assign addr_way   = addr_i[MASK_W+BLK_W];  // lowest index bit picks the way for a tag flush

  assign is_flush = (op_i != OP_LD) && (op_i != OP_ST);
  assign is_store = (op_i == OP_ST);
  assign is_inv   = (op_i == OP_AINV) || (op_i == OP_AFLINV);

  assign chosen_set_o = chosen_set_r;
  assign tag_if.data   = tag_wdata;
  assign tag_if.w_mask = tag_wmask;

  always_comb begin
    state_n        = state_r;
    chosen_set_n   = chosen_set_r;
    stat_flopped_n = stat_flopped_r;
    dirty_n        = dirty_r;
    mru_n          = mru_r;

    dma_send_fill_addr_o  = 1'b0;
    dma_send_evict_addr_o = 1'b0;
    dma_get_fill_data_o   = 1'b0;
    dma_send_evict_data_o = 1'b0;
    dma_set_o             = 1'b0;
    dma_addr_o            = '0;
    recover_o             = 1'b0;
    done_o                = 1'b0;

    tag_if.v     = 1'b0;
    tag_if.w     = 1'b0;
    tag_if.addr  = addr_index;
    tag_wdata    = '0;
    tag_wmask    = '0;
    stat_if.v    = 1'b0;
    stat_if.w    = 1'b0;
    stat_if.addr = addr_index;
    stat_if.data   = '0;
    stat_if.w_mask = '0;

    case (state_r)
      START: begin
        tag_if.v       = miss_v_i;  // both reads go out together
        stat_if.v      = miss_v_i;
        stat_flopped_n = 1'b0;
        if (miss_v_i) begin
          state_n = is_flush ? FLUSH_OP : SEND_FILL_ADDR;
        end
      end

      SEND_FILL_ADDR: begin
        stat_flopped_n = 1'b1;
        dirty_n = stat_flopped_r ? dirty_r : dirty_i;
        mru_n   = stat_flopped_r ? mru_r : mru_i;
        // an invalid way wins, otherwise the way that is not most recently used
        chosen_set_n = valid_i[0] ? (valid_i[1] ? ~mru_n : 1'b1) : 1'b0;

        dma_send_fill_addr_o = 1'b1;
        dma_addr_o = {addr_tag, addr_index, {(MASK_W+BLK_W){1'b0}}};

        stat_if.v      = dma_done_i;
        stat_if.w      = dma_done_i;
        stat_if.data   = {{2{is_store}}, chosen_set_n};
        stat_if.w_mask = {chosen_set_n, ~chosen_set_n, 1'b1};

        tag_if.v     = dma_done_i;
        tag_if.w     = dma_done_i;
        tag_wdata[0] = '{valid: 1'b1, tag: addr_tag};
        tag_wdata[1] = '{valid: 1'b1, tag: addr_tag};
        tag_wmask[0] = {($bits(tag_entry_t)){~chosen_set_n}};
        tag_wmask[1] = {($bits(tag_entry_t)){chosen_set_n}};

        if (dma_done_i) begin
          state_n = (dirty_n[chosen_set_n] & valid_i[chosen_set_n])
                  ? SEND_EVICT_ADDR : GET_FILL_DATA;
        end
      end

      FLUSH_OP: begin
        dirty_n = dirty_i;
        chosen_set_n = (op_i == OP_TAGFL) ? addr_way : hit_i[1];

        stat_if.v      = 1'b1;
        stat_if.w      = 1'b1;
        stat_if.data   = {2'b00, ~chosen_set_n};
        stat_if.w_mask = {chosen_set_n, ~chosen_set_n, 1'b1};

        tag_if.v           = 1'b1;
        tag_if.w           = 1'b1;
        tag_wmask[0].valid = is_inv & ~chosen_set_n;
        tag_wmask[1].valid = is_inv & chosen_set_n;

        state_n = ((op_i != OP_AINV) & dirty_n[chosen_set_n] & valid_i[chosen_set_n])
                ? SEND_EVICT_ADDR : RECOVER;
      end

      SEND_EVICT_ADDR: begin
        dma_send_evict_addr_o = 1'b1;
        dma_addr_o = {tags_i[chosen_set_r], addr_index, {(MASK_W+BLK_W){1'b0}}};
        if (dma_done_i) begin
          state_n = SEND_EVICT_DATA;
        end
      end

      SEND_EVICT_DATA: begin
        dma_send_evict_data_o = sbuf_empty_i;  // store buffer must drain first
        dma_set_o  = chosen_set_r;
        dma_addr_o = {tags_i[chosen_set_r], addr_index, {(MASK_W+BLK_W){1'b0}}};
        if (dma_done_i) begin
          state_n = is_flush ? RECOVER : GET_FILL_DATA;
        end
      end

      GET_FILL_DATA: begin
        dma_get_fill_data_o = sbuf_empty_i;
        dma_set_o  = chosen_set_r;
        dma_addr_o = {addr_tag, addr_index, addr_word, {MASK_W{1'b0}}};
        if (dma_done_i) begin
          state_n = RECOVER;
        end
      end

      RECOVER: begin
        recover_o = 1'b1;
        state_n   = DONE;
      end

      DONE: begin
        done_o = 1'b1;
        if (ack_i) begin
          state_n = START;
        end
      end

      default: begin
        state_n = START;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r        <= START;
      chosen_set_r   <= 1'b0;
      stat_flopped_r <= 1'b0;
    end else begin
      state_r        <= state_n;
      chosen_set_r   <= chosen_set_n;
      stat_flopped_r <= stat_flopped_n;
    end
  end

  always_ff @(posedge clk_i) begin
    dirty_r <= dirty_n;
    mru_r   <= mru_n;
  end

endmodule

/* cache_miss_assert.sv */
// protocol checker for the miss FSM covering DMA strobes, recover and the done handshake
`timescale 1ns/10ps

module cache_miss_assert (
  input logic                   clk_i,
  input logic                   reset_i,
  input cache_pkg::miss_state_e state_i,
  input logic [3:0]             strobe_i,  // fill addr, evict addr, fill data, evict data
  input logic                   recover_i,
  input logic                   done_i,
  input logic                   ack_i
);
  import cache_pkg::*;

  int unsigned fail_cnt = 0;  // read by the testbench

  a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(strobe_i))
    else begin
      $error("more than one DMA strobe high");
      fail_cnt++;
    end

  a_recover_done: assert property (@(posedge clk_i) disable iff (reset_i)
    recover_i |=> done_i)
    else begin
      $error("recover_o not followed by done_o");
      fail_cnt++;
    end

  a_done_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i && !ack_i |=> done_i && (state_i == DONE))
    else begin
      $error("done_o dropped before ack_i");
      fail_cnt++;
    end

endmodule

/* cache_miss_top.f */
cache_pkg.sv
cache_mem_if.sv
cache_tag_mem.sv
cache_stat_mem.sv
cache_miss.sv
cache_miss_top.sv
cache_miss_assert.sv
tb_cache_miss_top.sv

/* cache_miss_top.sv */
// cache miss handler top level that joins the tag memory, the status memory and the miss FSM
`timescale 1ns/10ps

module cache_miss_top #(
  parameter int ADDR_W      = cache_pkg::ADDR_W,
  parameter int DATA_W      = cache_pkg::DATA_W,
  parameter int BLOCK_WORDS = cache_pkg::BLOCK_WORDS,
  parameter int SETS        = cache_pkg::SETS
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 miss_v_i,
  input  cache_pkg::cache_op_e op_i,
  input  cache_pkg::addr_t     addr_i,
  input  logic                 sbuf_empty_i,
  input  logic                 dma_done_i,
  input  logic                 ack_i,
  output logic                 dma_send_fill_addr_o,
  output logic                 dma_send_evict_addr_o,
  output logic                 dma_get_fill_data_o,
  output logic                 dma_send_evict_data_o,
  output logic                 dma_set_o,
  output cache_pkg::addr_t     dma_addr_o,
  output logic                 recover_o,
  output logic                 done_o,
  output cache_pkg::way_t      chosen_set_o
);
  import cache_pkg::*;

  localparam int TAG_BITS = tag_width(ADDR_W, DATA_W, BLOCK_WORDS, SETS);
  localparam int TAG_LSB  = ADDR_W - TAG_BITS;

  tag_t [1:0] tags;
  logic [1:0] valid;
  logic [1:0] hit;
  logic [1:0] dirty;
  logic       mru;
  tag_t       addr_tag;

  assign addr_tag = addr_i[TAG_LSB +: TAG_BITS];

  cache_mem_if #(.WIDTH(2 * $bits(tag_entry_t))) tag_if ();
  cache_mem_if #(.WIDTH($bits(stat_t)))          stat_if ();

  cache_tag_mem #(
    .SETS  (SETS),
    .TAG_W (TAG_BITS)
  ) tag_mem_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mem_if     (tag_if.memory),
    .addr_tag_i (addr_tag),
    .tags_o     (tags),
    .valid_o    (valid),
    .hit_o      (hit)
  );

  cache_stat_mem #(
    .SETS (SETS)
  ) stat_mem_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .mem_if  (stat_if.memory),
    .dirty_o (dirty),
    .mru_o   (mru)
  );

  cache_miss #(
    .ADDR_W      (ADDR_W),
    .DATA_W      (DATA_W),
    .BLOCK_WORDS (BLOCK_WORDS),
    .SETS        (SETS)
  ) miss_i (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .miss_v_i              (miss_v_i),
    .op_i                  (op_i),
    .addr_i                (addr_i),
    .tags_i                (tags),
    .valid_i               (valid),
    .hit_i                 (hit),
    .dirty_i               (dirty),
    .mru_i                 (mru),
    .sbuf_empty_i          (sbuf_empty_i),
    .dma_done_i            (dma_done_i),
    .ack_i                 (ack_i),
    .dma_send_fill_addr_o  (dma_send_fill_addr_o),
    .dma_send_evict_addr_o (dma_send_evict_addr_o),
    .dma_get_fill_data_o   (dma_get_fill_data_o),
    .dma_send_evict_data_o (dma_send_evict_data_o),
    .dma_set_o             (dma_set_o),
    .dma_addr_o            (dma_addr_o),
    .recover_o             (recover_o),
    .done_o                (done_o),
    .chosen_set_o          (chosen_set_o),
    .tag_if                (tag_if.requester),
    .stat_if               (stat_if.requester)
  );

endmodule

/* cache_pkg.sv */
// cache miss handler package with address field widths, vector types and the op and state enums
package cache_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int BLOCK_WORDS = 8;
  localparam int SETS        = 16;

  // clog2 that never returns zero, so single-entry fields keep one bit
  function automatic int clog2_safe(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic int tag_width(int addr_w, int data_w, int block_words, int sets);
    return addr_w - clog2_safe(data_w / 8) - clog2_safe(block_words) - clog2_safe(sets);
  endfunction

  localparam int LG_SETS  = clog2_safe(SETS);
  localparam int LG_MASK  = clog2_safe(DATA_W / 8);
  localparam int LG_BLOCK = clog2_safe(BLOCK_WORDS);
  localparam int TAG_W    = ADDR_W - LG_MASK - LG_BLOCK - LG_SETS;

  // bit positions inside a status entry
  localparam int STAT_MRU    = 0;
  localparam int STAT_DIRTY0 = 1;
  localparam int STAT_DIRTY1 = 2;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [LG_SETS-1:0] index_t;
  typedef logic [2:0]         stat_t;  // dirty way 1, dirty way 0, mru
  typedef logic               way_t;

  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

  typedef enum logic [2:0] {
    OP_LD,
    OP_ST,
    OP_TAGFL,
    OP_AFL,
    OP_AFLINV,
    OP_AINV
  } cache_op_e;

  typedef enum logic [2:0] {
    START,
    FLUSH_OP,
    SEND_EVICT_ADDR,
    SEND_FILL_ADDR,
    SEND_EVICT_DATA,
    GET_FILL_DATA,
    RECOVER,
    DONE
  } miss_state_e;

endpackage

/* cache_stat_mem.sv */
// per-set dirty pair and mru bit array with registered read and bitwise masked write
`timescale 1ns/10ps

module cache_stat_mem #(
  parameter int SETS = 16
) (
  input  logic        clk_i,
  input  logic        reset_i,
  cache_mem_if.memory mem_if,
  output logic [1:0]  dirty_o,
  output logic        mru_o
);
  import cache_pkg::*;

  stat_t stat_r [SETS];
  stat_t rd_r;
  stat_t wdata;
  stat_t wmask;

  assign wdata = mem_if.data;
  assign wmask = mem_if.w_mask;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < SETS; s++) begin
        stat_r[s] <= '0;
      end
    end else if (mem_if.v & mem_if.w) begin
      stat_r[mem_if.addr] <= (stat_r[mem_if.addr] & ~wmask) | (wdata & wmask);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_r <= '0;
    end else if (mem_if.v & ~mem_if.w) begin
      rd_r <= stat_r[mem_if.addr];
    end
  end

  assign dirty_o = {rd_r[STAT_DIRTY1], rd_r[STAT_DIRTY0]};
  assign mru_o   = rd_r[STAT_MRU];

endmodule

/* cache_tag_mem.sv */
// two-way tag and valid array with registered read, per-way hit vector and masked write
`timescale 1ns/10ps

module cache_tag_mem #(
  parameter int SETS  = 16,
  parameter int TAG_W = 23
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  cache_mem_if.memory           mem_if,
  input  cache_pkg::tag_t       addr_tag_i,
  output cache_pkg::tag_t [1:0] tags_o,
  output logic [1:0]            valid_o,
  output logic [1:0]            hit_o
);
  import cache_pkg::*;

  tag_entry_t [1:0] wdata;
  tag_entry_t [1:0] wmask;

  logic [TAG_W-1:0] tag_r [SETS][2];
  logic [1:0]       valid_r [SETS];

  logic [TAG_W-1:0] rd_tag_r [2];
  logic [1:0]       rd_valid_r;

  logic wr_en;
  logic rd_en;

  assign wdata = mem_if.data;
  assign wmask = mem_if.w_mask;
  assign wr_en = mem_if.v & mem_if.w;
  assign rd_en = mem_if.v & ~mem_if.w;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < SETS; s++) begin
        valid_r[s] <= 2'b00;
      end
    end else if (wr_en) begin
      for (int k = 0; k < 2; k++) begin
        if (wmask[k].valid) begin
          valid_r[mem_if.addr][k] <= wdata[k].valid;
        end
      end
    end
  end

  // tag bits are merged under the mask
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int k = 0; k < 2; k++) begin
        tag_r[mem_if.addr][k] <= (tag_r[mem_if.addr][k] & ~wmask[k].tag)
                               | (wdata[k].tag & wmask[k].tag);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_tag_r[0] <= tag_r[mem_if.addr][0];
      rd_tag_r[1] <= tag_r[mem_if.addr][1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_valid_r <= 2'b00;
    end else if (rd_en) begin
      rd_valid_r <= valid_r[mem_if.addr];  // writes leave the held line alone
    end
  end

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      tags_o[k] = rd_tag_r[k];
      hit_o[k]  = rd_valid_r[k] & (rd_tag_r[k] == addr_tag_i);
    end
  end

  assign valid_o = rd_valid_r;

endmodule

/* tb_cache_miss_top.sv */
// testbench for the cache miss handler with random requests, a DMA responder and a reference model
`timescale 1ns/10ps

module tb_cache_miss_top;
  import cache_pkg::*;

  localparam int NUM_REQ      = 300;
  localparam int DONE_TIMEOUT = 200;
  localparam int LINE_LSB     = LG_MASK + LG_BLOCK;

  typedef enum logic [1:0] {EV_FILL_ADDR, EV_EVICT_ADDR, EV_EVICT_DATA, EV_FILL_DATA} dma_kind_e;

  typedef struct {
    dma_kind_e kind;
    addr_t     addr;
    way_t      way;
  } dma_ev_t;

  logic clk_i, reset_i, miss_v_i, sbuf_empty_i, dma_done_i, ack_i;
  cache_op_e op_i;
  addr_t addr_i, dma_addr_o;
  logic dma_send_fill_addr_o, dma_send_evict_addr_o, dma_get_fill_data_o, dma_send_evict_data_o;
  logic dma_set_o, recover_o, done_o;
  way_t chosen_set_o;

  tag_t m_tag [SETS][2];
  logic m_valid [SETS][2];
  logic m_dirty [SETS][2];
  logic m_mru [SETS];
  dma_ev_t exp_q [$];

  logic req_active;
  logic strobe_seen;
  int   wait_cnt;

  cache_miss_top cache_miss_top_i (.*);

  bind cache_miss cache_miss_assert assert_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .state_i   (state_r),
    .strobe_i  ({dma_send_fill_addr_o, dma_send_evict_addr_o,
                 dma_get_fill_data_o, dma_send_evict_data_o}),
    .recover_i (recover_o),
    .done_i    (done_o),
    .ack_i     (ack_i)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_on_error();
    $display("Test FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_way(string name, way_t got, way_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0b expected %0b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_kind(string name, dma_kind_e got, dma_kind_e exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      stop_on_error();
    end
  endtask

  function automatic void push_event(dma_kind_e kind, addr_t addr, way_t way);
    dma_ev_t ev;
    ev.kind = kind;
    ev.addr = addr;
    ev.way  = way;
    exp_q.push_back(ev);
  endfunction

  // predicts the DMA events and chosen way of one request and updates the model contents
  function automatic way_t predict(cache_op_e op, addr_t a);
    index_t idx;
    tag_t   tg;
    way_t   w;
    addr_t  line;
    addr_t  old_line;
    idx  = a[LINE_LSB +: LG_SETS];
    tg   = a[LINE_LSB+LG_SETS +: TAG_W];
    line = {a[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
    if (op == OP_LD || op == OP_ST) begin
      if (!m_valid[idx][0]) w = 1'b0;
      else if (!m_valid[idx][1]) w = 1'b1;
      else w = ~m_mru[idx];
      old_line = {m_tag[idx][w], idx, {LINE_LSB{1'b0}}};
      push_event(EV_FILL_ADDR, line, w);
      if (m_valid[idx][w] && m_dirty[idx][w]) begin
        push_event(EV_EVICT_ADDR, old_line, w);
        push_event(EV_EVICT_DATA, old_line, w);
      end
      push_event(EV_FILL_DATA, {a[ADDR_W-1:LG_MASK], {LG_MASK{1'b0}}}, w);
      m_tag[idx][w]   = tg;
      m_valid[idx][w] = 1'b1;
      m_dirty[idx][w] = (op == OP_ST);
      m_mru[idx]      = w;
    end else begin
      if (op == OP_TAGFL) w = a[LINE_LSB];
      else w = m_valid[idx][1] && (m_tag[idx][1] == tg);
      old_line = {m_tag[idx][w], idx, {LINE_LSB{1'b0}}};
      if (op != OP_AINV && m_valid[idx][w] && m_dirty[idx][w]) begin
        push_event(EV_EVICT_ADDR, old_line, w);
        push_event(EV_EVICT_DATA, old_line, w);
      end
      m_dirty[idx][w] = 1'b0;
      if (op == OP_AFLINV || op == OP_AINV) m_valid[idx][w] = 1'b0;
      m_mru[idx] = ~w;  // maintenance leaves the other way most recent
    end
    return w;
  endfunction

  function automatic tag_t absent_tag(index_t idx);
    tag_t t;
    do begin
      t = tag_t'(1 + $urandom % 5);  // few tags so that sets fill up
    end while ((m_valid[idx][0] && m_tag[idx][0] == t) || (m_valid[idx][1] && m_tag[idx][1] == t));
    return t;
  endfunction

  function automatic addr_t make_addr(tag_t t, index_t idx);
    addr_t a;
    a = (addr_t'(t) << (LINE_LSB + LG_SETS)) | (addr_t'(idx) << LINE_LSB);
    a = a | addr_t'($urandom % (1 << LINE_LSB));  // random word and byte
    return a;
  endfunction

  function automatic dma_kind_e strobe_kind();
    if (dma_send_fill_addr_o) return EV_FILL_ADDR;
    if (dma_send_evict_addr_o) return EV_EVICT_ADDR;
    if (dma_send_evict_data_o) return EV_EVICT_DATA;
    return EV_FILL_DATA;
  endfunction

  // DMA responder that raises done only while the strobe seen last cycle is still up
  always @(posedge clk_i) begin
    #1;
    if (reset_i) begin
      dma_done_i = 1'b0;
      wait_cnt   = -1;
    end else if (dma_done_i) begin
      dma_done_i   = 1'b0;
      wait_cnt     = -1;
      sbuf_empty_i = ($urandom % 4) != 0;
    end else if (strobe_seen) begin
      if (wait_cnt < 0) wait_cnt = int'($urandom % 4);
      if (wait_cnt == 0) begin
        dma_done_i = 1'b1;
      end else begin
        wait_cnt--;
        sbuf_empty_i = ($urandom % 4) != 0;
      end
    end else begin
      sbuf_empty_i = ($urandom % 4) != 0;
    end
  end

  always @(negedge clk_i) begin : monitor
    dma_ev_t ev;
    strobe_seen = !reset_i && (dma_send_fill_addr_o || dma_send_evict_addr_o
                             || dma_get_fill_data_o || dma_send_evict_data_o);
    if (!reset_i) begin
      if (cache_miss_top_i.miss_i.assert_i.fail_cnt != 0) begin
        $display("assertion failure reported by the miss FSM checker");
        stop_on_error();
      end
      if (!req_active && (strobe_seen || done_o || recover_o)) begin
        $display("DMA strobe, recover_o or done_o high while idle at %0t", $time);
        stop_on_error();
      end
      if (dma_done_i && strobe_seen) begin
        if (exp_q.size() == 0) begin
          $display("unexpected DMA event at %0t", $time);
          stop_on_error();
        end
        ev = exp_q.pop_front();
        check_kind("dma strobe", strobe_kind(), ev.kind);
        check_addr("dma_addr_o", dma_addr_o, ev.addr);
        if (ev.kind == EV_FILL_DATA || ev.kind == EV_EVICT_DATA) begin
          check_way("dma_set_o", dma_set_o, ev.way);
        end
      end
    end
  end

  task automatic run_request(cache_op_e op, addr_t a, way_t exp_way);
    int   cnt;
    logic rec_seen;
    @(posedge clk_i);
    #1;
    op_i       = op;
    addr_i     = a;
    miss_v_i   = 1'b1;
    req_active = 1'b1;
    cnt = 0;
    rec_seen = 1'b0;
    do begin
      @(negedge clk_i);
      cnt++;
      if (!done_o) rec_seen = recover_o;
    end while (!done_o && cnt < DONE_TIMEOUT);
    if (!done_o) begin
      $display("timeout, done_o did not rise within %0d cycles", DONE_TIMEOUT);
      stop_on_error();
    end
    if (exp_q.size() != 0) begin
      $display("request ended with %0d DMA events still expected", exp_q.size());
      stop_on_error();
    end
    check_bit("recover_o", rec_seen, 1'b1);
    check_way("chosen_set_o", chosen_set_o, exp_way);
    @(posedge clk_i);
    #1 ack_i = 1'b1;
    @(posedge clk_i);
    #1;
    ack_i      = 1'b0;
    miss_v_i   = 1'b0;
    req_active = 1'b0;
  endtask

  initial begin
    cache_op_e op;
    index_t    idx;
    tag_t      tg;
    way_t      exp_way;
    int        r;
    void'($urandom(86023));
    clk_i = 1'b0;
    reset_i = 1'b1;
    miss_v_i = 1'b0;
    op_i = OP_LD;
    addr_i = '0;
    sbuf_empty_i = 1'b1;
    dma_done_i = 1'b0;
    ack_i = 1'b0;
    req_active = 1'b0;
    strobe_seen = 1'b0;
    wait_cnt = -1;
    for (int s = 0; s < SETS; s++) begin
      m_mru[s] = 1'b0;
      for (int k = 0; k < 2; k++) begin
        m_tag[s][k] = '0;
        m_valid[s][k] = 1'b0;
        m_dirty[s][k] = 1'b0;
      end
    end
    repeat (8) @(posedge clk_i);
    #1 reset_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_way("chosen_set_o", chosen_set_o, 1'b0);
    for (int n = 0; n < NUM_REQ; n++) begin
      idx = index_t'($urandom % 4);
      r = $urandom % 11;
      if (r < 4) op = OP_LD;
      else if (r < 7) op = OP_ST;
      else if (r == 7) op = OP_TAGFL;
      else if (r == 8) op = OP_AFL;
      else if (r == 9) op = OP_AFLINV;
      else op = OP_AINV;
      tg = tag_t'(1 + $urandom % 5);
      if (op == OP_AFL || op == OP_AFLINV || op == OP_AINV) begin
        if (m_valid[idx][0] && m_valid[idx][1]) tg = m_tag[idx][$urandom % 2];
        else if (m_valid[idx][0] || m_valid[idx][1]) tg = m_tag[idx][m_valid[idx][1]];
        else op = OP_LD;  // address flushes target a resident line
      end
      if (op == OP_LD || op == OP_ST) tg = absent_tag(idx);
      begin
        addr_t a;
        a = make_addr(tg, idx);
        exp_way = predict(op, a);
        run_request(op, a, exp_way);
      end
      repeat ($urandom % 3) @(posedge clk_i);
    end
    repeat (4) @(posedge clk_i);
    if (cache_miss_top_i.miss_i.assert_i.fail_cnt == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("assertion failures in the miss FSM checker");
      stop_on_error();
    end
  end

endmodule
